/* logic/trap_pkg.sv */
// machine-mode only, RV32 widths fixed; covers just the four trap CSRs and the ecall/ebreak/mret/csrrw encodings
`default_nettype none

package trap_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // system opcode and funct fields
    localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
    localparam logic [2:0]  F3_PRIV    = 3'b000;     // ecall, ebreak, mret
    localparam logic [2:0]  F3_CSRRW   = 3'b001;
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;

    // trap csr addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

    localparam logic [XLEN-1:0] CAUSE_ECALL_M    = 32'd11;
    localparam logic [XLEN-1:0] CAUSE_BREAKPOINT = 32'd3;

    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // sequencer states, one-hot
    localparam int         SEQ_ST_W     = 5;
    localparam logic [4:0] SEQ_IDLE     = 5'b00001;
    localparam logic [4:0] SEQ_MEPC     = 5'b00010;  // trap, write mepc
    localparam logic [4:0] SEQ_MSTATUS  = 5'b00100;  // trap, stack mie
    localparam logic [4:0] SEQ_MCAUSE   = 5'b01000;  // trap, cause + redirect
    localparam logic [4:0] SEQ_MRET     = 5'b10000;  // return, unstack + redirect

    // one instruction word, two views of the upper 12 bits
    typedef struct packed {
        logic [11:0] funct12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } priv_view_t;

    typedef struct packed {
        logic [11:0] csr_addr;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_view_t;

    typedef union packed {
        priv_view_t priv;  // ecall / ebreak / mret
        csr_view_t  csr;   // csrrw
    } instr_word_u;

endpackage

`default_nettype wire

/* logic/sys_decoder.sv */
// no handshake: instructions seen while the sequencer is busy or a trap is held by an atomic op are dropped
`timescale 1ns/1ns
`default_nettype none

module sys_decoder
    import trap_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   instr_valid_i,
    input  wire instr_word_u      instr_i,
    input  wire [XLEN-1:0]        pc_i,
    input  wire                   jump_flag_i,
    input  wire [XLEN-1:0]        jump_addr_i,
    input  wire [XLEN-1:0]        rs1_data_i,
    input  wire                   atom_busy_i,
    input  wire                   seq_busy_i,
    output logic                  ecall_o,
    output logic                  ebreak_o,
    output logic                  mret_o,
    output logic                  csrrw_o,
    output logic [XLEN-1:0]       pc_o,
    output logic                  jump_o,
    output logic [XLEN-1:0]       jump_addr_o,
    output logic [CSR_ADDR_W-1:0] csr_addr_o,
    output logic [XLEN-1:0]       wdata_o
);

    logic is_system;
    logic is_priv;
    logic hold;    // trap pulse out while atomic busy
    logic accept;

    assign is_system = (instr_i.priv.opcode == OPC_SYSTEM);
    assign is_priv   = is_system && (instr_i.priv.funct3 == F3_PRIV);
    assign hold      = (ecall_o | ebreak_o) & atom_busy_i;  // front end waits out the stall
    assign accept    = instr_valid_i & ~seq_busy_i & ~hold;

    // one pulse per accepted instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ecall_o  <= 1'b0;
            ebreak_o <= 1'b0;
            mret_o   <= 1'b0;
            csrrw_o  <= 1'b0;
        end else begin
            ecall_o  <= accept && is_priv && (instr_i.priv.funct12 == F12_ECALL);
            ebreak_o <= accept && is_priv && (instr_i.priv.funct12 == F12_EBREAK);
            mret_o   <= accept && is_priv && (instr_i.priv.funct12 == F12_MRET);
            csrrw_o  <= accept && is_system && (instr_i.csr.funct3 == F3_CSRRW);
        end
    end

    // operands beside the pulses, only meaningful with one
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            pc_o        <= pc_i;
            jump_o      <= jump_flag_i;
            jump_addr_o <= jump_addr_i;
            csr_addr_o  <= instr_i.csr.csr_addr;  // same bits as funct12
            wdata_o     <= rs1_data_i;
        end
    end

endmodule

`default_nettype wire

/* logic/trap_sequencer.sv */
// synchronous traps only, no interrupts; a trap pulse meeting atom_busy_i is stalled and dropped, not retried
`timescale 1ns/1ns
`default_nettype none

module trap_sequencer
    import trap_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   ecall_i,
    input  wire                   ebreak_i,
    input  wire                   mret_i,
    input  wire [XLEN-1:0]        pc_i,
    input  wire                   jump_i,
    input  wire [XLEN-1:0]        jump_addr_i,
    input  wire                   atom_busy_i,
    input  wire [XLEN-1:0]        mtvec_i,
    input  wire [XLEN-1:0]        mepc_i,
    input  wire [XLEN-1:0]        mstatus_i,
    output logic                  csr_we_o,
    output logic [CSR_ADDR_W-1:0] csr_waddr_o,
    output logic [XLEN-1:0]       csr_wdata_o,
    output logic                  redirect_valid_o,
    output logic [XLEN-1:0]       redirect_addr_o,
    output logic                  flush_o,
    output logic                  stall_o,
    output logic                  busy_o
);

    logic [SEQ_ST_W-1:0] state;
    logic [XLEN-1:0]     epc_q;     // return pc latched on entry
    logic [XLEN-1:0]     cause_q;
    logic                is_trap;   // ecall or ebreak pulse
    logic                take_trap;
    logic [XLEN-1:0]     mstatus_trap;
    logic [XLEN-1:0]     mstatus_ret;

    assign is_trap   = ecall_i | ebreak_i;
    assign take_trap = is_trap & ~atom_busy_i & (state == SEQ_IDLE);

    assign stall_o = is_trap & atom_busy_i;  // held trap, not taken
    assign flush_o = (state != SEQ_IDLE);
    // blocks the decoder from the entry cycle on
    assign busy_o  = flush_o | take_trap | mret_i;

    // mstatus edits from the live value
    always_comb begin
        mstatus_trap               = mstatus_i;
        mstatus_trap[MSTATUS_MPIE] = mstatus_i[MSTATUS_MIE];   // keep old mie
        mstatus_trap[MSTATUS_MIE]  = 1'b0;
        mstatus_ret                = mstatus_i;
        mstatus_ret[MSTATUS_MIE]   = mstatus_i[MSTATUS_MPIE];  // restore
        mstatus_ret[MSTATUS_MPIE]  = 1'b1;
    end

    // state transitions
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEQ_IDLE;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (take_trap) begin
                        state <= SEQ_MEPC;
                    end else if (mret_i) begin
                        state <= SEQ_MRET;
                    end
                end
                SEQ_MEPC:    state <= SEQ_MSTATUS;
                SEQ_MSTATUS: state <= SEQ_MCAUSE;
                SEQ_MCAUSE:  state <= SEQ_IDLE;
                SEQ_MRET:    state <= SEQ_IDLE;
                default:     state <= SEQ_IDLE;  // illegal one-hot code
            endcase
        end
    end

    // return pc and cause, captured on entry
    always_ff @(posedge clk) begin
        if (take_trap) begin
            epc_q   <= jump_i ? (jump_addr_i - XLEN'(4)) : pc_i;  // branch target in flight
            cause_q <= ecall_i ? CAUSE_ECALL_M : CAUSE_BREAKPOINT;
        end
    end

    // write strobe and redirect pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_we_o         <= 1'b0;
            redirect_valid_o <= 1'b0;
        end else begin
            csr_we_o         <= (state != SEQ_IDLE);  // one write per busy state
            redirect_valid_o <= (state == SEQ_MCAUSE) || (state == SEQ_MRET);
        end
    end

    // write address/data and redirect target
    always_ff @(posedge clk) begin
        case (state)
            SEQ_MEPC: begin
                csr_waddr_o <= CSR_MEPC;
                csr_wdata_o <= epc_q;
            end
            SEQ_MSTATUS: begin
                csr_waddr_o <= CSR_MSTATUS;
                csr_wdata_o <= mstatus_trap;
            end
            SEQ_MCAUSE: begin
                csr_waddr_o     <= CSR_MCAUSE;
                csr_wdata_o     <= cause_q;
                redirect_addr_o <= mtvec_i;  // enter handler
            end
            SEQ_MRET: begin
                csr_waddr_o     <= CSR_MSTATUS;
                csr_wdata_o     <= mstatus_ret;
                redirect_addr_o <= mepc_i;   // back to saved pc
            end
            default: begin
                // idle, hold payload
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/machine_csr_file.sv */
// only mtvec, mepc, mstatus, mcause exist; csrrw elsewhere reads zero and writes nothing, no access checks
`timescale 1ns/1ns
`default_nettype none

module machine_csr_file
    import trap_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   seq_we_i,
    input  wire [CSR_ADDR_W-1:0]  seq_waddr_i,
    input  wire [XLEN-1:0]        seq_wdata_i,
    input  wire                   csrrw_i,
    input  wire [CSR_ADDR_W-1:0]  csr_addr_i,
    input  wire [XLEN-1:0]        wdata_i,
    output logic [XLEN-1:0]       mtvec_o,
    output logic [XLEN-1:0]       mepc_o,
    output logic [XLEN-1:0]       mstatus_o,
    output logic                  rd_valid_o,
    output logic [XLEN-1:0]       rd_data_o
);

    logic [XLEN-1:0] mcause_q;  // only visible through csrrw
    logic [XLEN-1:0] old_val;   // csrrw read side

    // next value of one csr, sequencer port wins a same-address clash
    function automatic logic [XLEN-1:0] csr_next(
        input logic [CSR_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       cur
    );
        logic [XLEN-1:0] nxt;
        nxt = cur;
        if (seq_we_i && (seq_waddr_i == addr)) begin
            nxt = seq_wdata_i;
        end else if (csrrw_i && (csr_addr_i == addr)) begin
            nxt = wdata_i;                        // csrrw write half
        end
        return nxt;
    endfunction

    // read mux, unknown address reads zero
    always_comb begin
        case (csr_addr_i)
            CSR_MTVEC:   old_val = mtvec_o;
            CSR_MEPC:    old_val = mepc_o;
            CSR_MSTATUS: old_val = mstatus_o;
            CSR_MCAUSE:  old_val = mcause_q;
            default:     old_val = '0;
        endcase
    end

    // the four registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_o   <= '0;
            mepc_o    <= '0;
            mstatus_o <= '0;
            mcause_q  <= '0;
        end else begin
            mtvec_o   <= csr_next(CSR_MTVEC, mtvec_o);
            mepc_o    <= csr_next(CSR_MEPC, mepc_o);
            mstatus_o <= csr_next(CSR_MSTATUS, mstatus_o);
            mcause_q  <= csr_next(CSR_MCAUSE, mcause_q);
        end
    end

    // result pulse, one cycle after the csrrw strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= csrrw_i;
        end
    end

    // old value, sampled before the write lands
    always_ff @(posedge clk) begin
        if (csrrw_i) begin
            rd_data_o <= old_val;
        end
    end

endmodule

`default_nettype wire

/* logic/trap_unit_top.sv */
// no back-pressure: strobe instructions only while flush_o is low, redirect and result are one-cycle pulses
`timescale 1ns/1ns
`default_nettype none

module trap_unit_top
    import trap_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               instr_valid_i,
    input  wire instr_word_u  instr_i,
    input  wire [XLEN-1:0]    pc_i,
    input  wire               jump_flag_i,
    input  wire [XLEN-1:0]    jump_addr_i,
    input  wire               atom_busy_i,
    input  wire [XLEN-1:0]    rs1_data_i,
    output logic              redirect_valid_o,
    output logic [XLEN-1:0]   redirect_addr_o,
    output logic              flush_o,
    output logic              stall_o,
    output logic              csr_rd_valid_o,
    output logic [XLEN-1:0]   csr_rd_data_o
);

    // decoder to sequencer / csr file
    logic                  dec_ecall;
    logic                  dec_ebreak;
    logic                  dec_mret;
    logic                  dec_csrrw;
    logic [XLEN-1:0]       dec_pc;
    logic                  dec_jump;
    logic [XLEN-1:0]       dec_jump_addr;
    logic [CSR_ADDR_W-1:0] dec_csr_addr;
    logic [XLEN-1:0]       dec_wdata;
    logic                  seq_busy;
    // sequencer write port
    logic                  seq_we;
    logic [CSR_ADDR_W-1:0] seq_waddr;
    logic [XLEN-1:0]       seq_wdata;
    // live csr values back to the sequencer
    logic [XLEN-1:0]       mtvec;
    logic [XLEN-1:0]       mepc;
    logic [XLEN-1:0]       mstatus;

    sys_decoder sys_decoder_i (
        .clk(clk), .rst_n(rst_n),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i), .pc_i(pc_i),
        .jump_flag_i(jump_flag_i), .jump_addr_i(jump_addr_i), .rs1_data_i(rs1_data_i),
        .atom_busy_i(atom_busy_i), .seq_busy_i(seq_busy),
        .ecall_o(dec_ecall), .ebreak_o(dec_ebreak), .mret_o(dec_mret), .csrrw_o(dec_csrrw),
        .pc_o(dec_pc), .jump_o(dec_jump), .jump_addr_o(dec_jump_addr),
        .csr_addr_o(dec_csr_addr), .wdata_o(dec_wdata)
    );

    trap_sequencer trap_sequencer_i (
        .clk(clk), .rst_n(rst_n),
        .ecall_i(dec_ecall), .ebreak_i(dec_ebreak), .mret_i(dec_mret),
        .pc_i(dec_pc), .jump_i(dec_jump), .jump_addr_i(dec_jump_addr),
        .atom_busy_i(atom_busy_i),
        .mtvec_i(mtvec), .mepc_i(mepc), .mstatus_i(mstatus),
        .csr_we_o(seq_we), .csr_waddr_o(seq_waddr), .csr_wdata_o(seq_wdata),
        .redirect_valid_o(redirect_valid_o), .redirect_addr_o(redirect_addr_o),
        .flush_o(flush_o), .stall_o(stall_o), .busy_o(seq_busy)
    );

    machine_csr_file machine_csr_file_i (
        .clk(clk), .rst_n(rst_n),
        .seq_we_i(seq_we), .seq_waddr_i(seq_waddr), .seq_wdata_i(seq_wdata),
        .csrrw_i(dec_csrrw), .csr_addr_i(dec_csr_addr), .wdata_i(dec_wdata),
        .mtvec_o(mtvec), .mepc_o(mepc), .mstatus_o(mstatus),
        .rd_valid_o(csr_rd_valid_o), .rd_data_o(csr_rd_data_o)
    );

endmodule

`default_nettype wire

/* testbench/trap_unit_tb.sv */
// one instruction in flight at a time, next strobe only after the result and flush low; seed fixed
`timescale 1ns/1ns
`default_nettype none

module trap_unit_tb
    import trap_pkg::*;
();

    localparam int N_TESTS    = 240;  // directed plus random rounded up
    localparam int RESET_CYC  = 16;
    localparam int TIMEOUT_NS = (RESET_CYC + 40 * N_TESTS) * 10;
    localparam int K_ECALL    = 0;
    localparam int K_EBREAK   = 1;
    localparam int K_MRET     = 2;
    localparam int K_CSRRW    = 3;
    localparam logic [CSR_ADDR_W-1:0] CSR_NONE = 12'h7c0;  // not implemented

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    instr_word_u     instr;
    logic [XLEN-1:0] pc;
    logic            jump_flag;
    logic [XLEN-1:0] jump_addr;
    logic            atom_busy;
    logic [XLEN-1:0] rs1_data;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_addr;
    logic            flush;
    logic            stall;
    logic            csr_rd_valid;
    logic [XLEN-1:0] csr_rd_data;

    logic [XLEN-1:0] sh_mtvec;    // model copies of the csrs
    logic [XLEN-1:0] sh_mepc;
    logic [XLEN-1:0] sh_mstatus;
    logic [XLEN-1:0] sh_mcause;
    logic [XLEN-1:0] redir_exp[$];
    int              redir_due[$];  // cycle the pulse must show in
    logic [XLEN-1:0] rd_exp[$];
    int              rd_due[$];
    int              flush_from = 1;  // cycles where flush must be high
    int              flush_to = 0;
    int              cyc = 0;
    int              mismatch_cnt = 0;
    int              other_cnt = 0;

    trap_unit_top trap_unit_top_i (
        .clk(clk), .rst_n(rst_n),
        .instr_valid_i(instr_valid), .instr_i(instr), .pc_i(pc),
        .jump_flag_i(jump_flag), .jump_addr_i(jump_addr),
        .atom_busy_i(atom_busy), .rs1_data_i(rs1_data),
        .redirect_valid_o(redirect_valid), .redirect_addr_o(redirect_addr),
        .flush_o(flush), .stall_o(stall),
        .csr_rd_valid_o(csr_rd_valid), .csr_rd_data_o(csr_rd_data)
    );

    always #5 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;  // edge count read on falling edges

    function automatic instr_word_u build_instr(input int kind, input logic [CSR_ADDR_W-1:0] addr);
        instr_word_u w;
        w = '0;
        w.priv.opcode = OPC_SYSTEM;
        w.priv.funct3 = F3_PRIV;
        case (kind)
            K_ECALL:  w.priv.funct12 = F12_ECALL;
            K_EBREAK: w.priv.funct12 = F12_EBREAK;
            K_MRET:   w.priv.funct12 = F12_MRET;
            default: begin
                w.csr.funct3   = F3_CSRRW;
                w.csr.csr_addr = addr;
                w.csr.rd       = 5'd1;
                w.csr.rs1      = 5'd2;  // register numbers are don't care here
            end
        endcase
        return w;
    endfunction

    function automatic logic [CSR_ADDR_W-1:0] pick_addr(input int sel);
        case (sel)
            0:       return CSR_MTVEC;
            1:       return CSR_MEPC;
            2:       return CSR_MSTATUS;
            3:       return CSR_MCAUSE;
            default: return CSR_NONE;
        endcase
    endfunction

    // trap pushes mie into mpie and mret pops it back
    function automatic logic [XLEN-1:0] next_mstatus(input logic [XLEN-1:0] cur, input logic ret);
        logic [XLEN-1:0] nxt;
        nxt = cur;
        if (ret) begin
            nxt[MSTATUS_MIE]  = cur[MSTATUS_MPIE];
            nxt[MSTATUS_MPIE] = 1'b1;
        end else begin
            nxt[MSTATUS_MPIE] = cur[MSTATUS_MIE];
            nxt[MSTATUS_MIE]  = 1'b0;
        end
        return nxt;
    endfunction

    function automatic logic [XLEN-1:0] read_shadow(input logic [CSR_ADDR_W-1:0] addr);
        case (addr)
            CSR_MTVEC:   return sh_mtvec;
            CSR_MEPC:    return sh_mepc;
            CSR_MSTATUS: return sh_mstatus;
            CSR_MCAUSE:  return sh_mcause;
            default:     return '0;  // unknown reads zero
        endcase
    endfunction

    // expected pulses and csr updates for one strobed instruction
    task automatic model_step(input int kind, input logic [CSR_ADDR_W-1:0] addr,
                              input logic [XLEN-1:0] at_pc, input logic jmp,
                              input logic [XLEN-1:0] jmp_addr, input logic [XLEN-1:0] data,
                              input logic held);
        int edge0;
        edge0 = cyc + 1;  // next rising edge samples the strobe
        if (kind == K_CSRRW) begin
            rd_exp.push_back(read_shadow(addr));
            rd_due.push_back(edge0 + 1);
            case (addr)
                CSR_MTVEC:   sh_mtvec = data;
                CSR_MEPC:    sh_mepc = data;
                CSR_MSTATUS: sh_mstatus = data;
                CSR_MCAUSE:  sh_mcause = data;
                default:     ;  // nothing written
            endcase
        end else if (kind == K_MRET) begin
            redir_exp.push_back(sh_mepc);
            redir_due.push_back(edge0 + 2);
            flush_from = edge0 + 1;  // return state only
            flush_to   = edge0 + 1;
            sh_mstatus = next_mstatus(sh_mstatus, 1'b1);
        end else if (!held) begin
            redir_exp.push_back(sh_mtvec);
            redir_due.push_back(edge0 + 4);
            flush_from = edge0 + 1;  // three write states
            flush_to   = edge0 + 3;
            sh_mepc    = jmp ? (jmp_addr - 32'd4) : at_pc;
            sh_mstatus = next_mstatus(sh_mstatus, 1'b0);
            sh_mcause  = (kind == K_ECALL) ? CAUSE_ECALL_M : CAUSE_BREAKPOINT;
        end
    endtask

    task automatic check_redirect(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                                  input int due);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: redirect to %h, expected %h", $time, got, exp);
        end
        if (cyc != due) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: redirect in cycle %0d, expected %0d", $time, cyc, due);
        end
    endtask

    task automatic check_csr_read(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                                  input int due);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: csr read %h, expected %h", $time, got, exp);
        end
        if (cyc != due) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: csr read in cycle %0d, expected %0d", $time, cyc, due);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: stall %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_flush(input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: flush %b, expected %b", $time, got, exp);
        end
    endtask

    // drive on a falling edge and return once the result is out and flush is low
    task automatic send(input int kind, input logic [CSR_ADDR_W-1:0] addr,
                        input logic [XLEN-1:0] at_pc, input logic jmp,
                        input logic [XLEN-1:0] jmp_addr, input logic [XLEN-1:0] data,
                        input logic held);
        int waited;
        waited      = 0;
        instr       = build_instr(kind, addr);
        pc          = at_pc;
        jump_flag   = jmp;
        jump_addr   = jmp_addr;
        rs1_data    = data;
        atom_busy   = held;
        instr_valid = 1'b1;
        model_step(kind, addr, at_pc, jmp, jmp_addr, data, held);
        @(negedge clk);
        instr_valid = 1'b0;
        if (held) begin
            check_stall(stall, 1'b1);
            @(negedge clk);  // busy kept over edge 1 so the trap is dropped
            check_stall(stall, 1'b0);
            atom_busy = 1'b0;
        end else begin
            while (!(redirect_valid || csr_rd_valid) && waited < 40) begin
                @(negedge clk);
                waited++;
            end
            if (waited >= 40) begin
                other_cnt++;
                $display("no result pulse within 40 cycles at %0t ns", $time);
            end
        end
        while (flush) begin
            @(negedge clk);
        end
    endtask

    // compares every result pulse and the flush level with the model
    always @(negedge clk) begin
        if (rst_n) begin
            check_flush(flush, (cyc >= flush_from) && (cyc <= flush_to));
            if (redir_due.size() > 0 && redir_due[0] < cyc) begin
                other_cnt++;
                $display("redirect due in cycle %0d never came", redir_due[0]);
                redir_exp.delete(0);
                redir_due.delete(0);
            end
            if (rd_due.size() > 0 && rd_due[0] < cyc) begin
                other_cnt++;
                $display("csr read due in cycle %0d never came", rd_due[0]);
                rd_exp.delete(0);
                rd_due.delete(0);
            end
            if (redirect_valid && redir_exp.size() == 0) begin
                other_cnt++;
                $display("unexpected redirect to %h at %0t ns", redirect_addr, $time);
            end else if (redirect_valid) begin
                check_redirect(redirect_addr, redir_exp[0], redir_due[0]);
                redir_exp.delete(0);
                redir_due.delete(0);
            end
            if (csr_rd_valid && rd_exp.size() == 0) begin
                other_cnt++;
                $display("unexpected csr read result at %0t ns", $time);
            end else if (csr_rd_valid) begin
                check_csr_read(csr_rd_data, rd_exp[0], rd_due[0]);
                rd_exp.delete(0);
                rd_due.delete(0);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, run did not finish", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        int              n;
        int              r;
        int              kind;
        logic            jmp;
        logic            held;
        logic [XLEN-1:0] tpc;
        void'($urandom(42280));
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        jump_flag = 1'b0;
        jump_addr = '0;
        atom_busy = 1'b0;
        rs1_data = '0;
        sh_mtvec = '0;
        sh_mepc = '0;
        sh_mstatus = '0;
        sh_mcause = '0;
        repeat (RESET_CYC) @(negedge clk);
        if (redirect_valid || csr_rd_valid || flush || stall) begin
            other_cnt++;
            $display("outputs not idle during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        // csrrw round trips and then an unknown address
        for (n = 0; n < 8; n++) begin
            send(K_CSRRW, pick_addr(n % 4), '0, 1'b0, '0, $urandom, 1'b0);
        end
        send(K_CSRRW, CSR_NONE, '0, 1'b0, '0, $urandom, 1'b0);
        // ecall with mie set and jump flag clear
        send(K_CSRRW, CSR_MSTATUS, '0, 1'b0, '0, 32'h0000_0008, 1'b0);
        send(K_CSRRW, CSR_MTVEC, '0, 1'b0, '0, 32'h0000_1000, 1'b0);
        tpc = $urandom & 32'hffff_fffc;
        send(K_ECALL, '0, tpc, 1'b0, $urandom, $urandom, 1'b0);
        send(K_CSRRW, CSR_MEPC, '0, 1'b0, '0, $urandom, 1'b0);
        send(K_CSRRW, CSR_MCAUSE, '0, 1'b0, '0, $urandom, 1'b0);
        send(K_CSRRW, CSR_MSTATUS, '0, 1'b0, '0, 32'h0000_0080, 1'b0);
        // ebreak on a branch target
        send(K_EBREAK, '0, tpc, 1'b1, $urandom & 32'hffff_fffc, $urandom, 1'b0);
        send(K_CSRRW, CSR_MEPC, '0, 1'b0, '0, $urandom, 1'b0);
        send(K_CSRRW, CSR_MCAUSE, '0, 1'b0, '0, $urandom, 1'b0);
        // mret with mpie set
        send(K_CSRRW, CSR_MSTATUS, '0, 1'b0, '0, 32'h0000_0080, 1'b0);
        send(K_MRET, '0, tpc, 1'b0, '0, '0, 1'b0);
        send(K_CSRRW, CSR_MSTATUS, '0, 1'b0, '0, 32'h0000_0008, 1'b0);
        // ecall held by an atomic op so the csrs must stay put
        send(K_ECALL, '0, $urandom, 1'b0, $urandom, '0, 1'b1);
        for (n = 0; n < 4; n++) begin
            send(K_CSRRW, pick_addr(n), '0, 1'b0, '0, $urandom, 1'b0);
        end
        // random mix
        for (n = 0; n < 200; n++) begin
            r    = $urandom_range(9, 0);
            kind = (r < 2) ? K_ECALL : (r < 4) ? K_EBREAK : (r == 4) ? K_MRET : K_CSRRW;
            jmp  = 1'($urandom_range(1, 0));
            held = (kind <= K_EBREAK) && ($urandom_range(7, 0) == 0);
            send(kind, pick_addr($urandom_range(4, 0)), $urandom & 32'hffff_fffc, jmp,
                 $urandom & 32'hffff_fffc, $urandom, held);
        end
        repeat (4) @(negedge clk);  // let the checker see the last pulse
        if (redir_exp.size() != 0 || rd_exp.size() != 0) begin
            other_cnt++;
            $display("%0d redirects and %0d csr reads still outstanding",
                     redir_exp.size(), rd_exp.size());
        end
        $display("summary: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
logic/trap_pkg.sv
logic/sys_decoder.sv
logic/trap_sequencer.sv
logic/machine_csr_file.sv
logic/trap_unit_top.sv
testbench/trap_unit_tb.sv

/* Makefile */
# Verilator build and run for the trap unit testbench
VERILATOR ?= verilator
TOP       ?= trap_unit_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
